/* bench/lpif_link_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Loopback testbench for the logic link top. Each tx lane feeds its rx lane
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "lpif_consts.svh"

module lpif_link_tb;

  localparam int HALF_PERIOD    = 4;
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int NUM_RANDOM     = 200;
  localparam int SUPER_W        = `LPIF_LANES * `LPIF_SLICE_W;
  // Valid bit of the super word sits in lane 3
  localparam int VLD_BIT        = `LPIF_FLIT_W - 3 * `LPIF_SLICE_W;

  logic                    clk_wr;
  logic                    arst_n;
  logic                    tx_online;
  logic                    rx_online;
  logic [3:0]              tx_mrk_userbit;
  lpif_pkg::delay_t        delay_x_value;
  lpif_pkg::delay_t        delay_y_value;
  lpif_pkg::credit_t       init_downstream_credit;
  logic                    dstrm_valid;
  logic [3:0]              dstrm_state;
  logic [1:0]              dstrm_protid;
  logic [`LPIF_DATA_W-1:0] dstrm_data;
  logic                    dstrm_credit;
  logic                    ustrm_valid;
  logic [3:0]              ustrm_state;
  logic [1:0]              ustrm_protid;
  logic [`LPIF_DATA_W-1:0] ustrm_data;
  logic                    ustrm_ready;
  logic [31:0]             tx_debug_status;
  logic [31:0]             rx_debug_status;
  lpif_pkg::lane_word_t    tx_phy0;
  lpif_pkg::lane_word_t    tx_phy1;
  lpif_pkg::lane_word_t    tx_phy2;
  lpif_pkg::lane_word_t    tx_phy3;
  lpif_pkg::lane_word_t    rx_phy0;
  lpif_pkg::lane_word_t    rx_phy1;
  lpif_pkg::lane_word_t    rx_phy2;
  lpif_pkg::lane_word_t    rx_phy3;

  // Scoreboard state
  lpif_pkg::flit_t exp_q  [$];
  lpif_pkg::flit_t lane_q [$];
  lpif_pkg::flit_t mon_flit;
  logic [2:0]      pop_hist;
  logic [31:0]     rng;
  int              pushed_cnt;
  int              credit_cnt;
  int              cycle_cnt;

  lpif_link_top lpif_link_top_i (.*);

  // PHY loopback
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1;
  assign rx_phy2 = tx_phy2;
  assign rx_phy3 = tx_phy3;

  always #HALF_PERIOD clk_wr = ~clk_wr;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Expected lanes {lane3, lane2, lane1, lane0} for one super word
  function automatic logic [79:0] lane_pack(input lpif_pkg::flit_t flit, input logic vld,
                                            input logic crd, input logic stb,
                                            input logic [3:0] mrk);
    logic [SUPER_W-1:0] sup;
    logic [79:0]        lanes;
    sup = {mrk, crd, vld, flit};
    for (int i = 0; i < `LPIF_LANES; i++) begin
      lanes[i*`LPIF_LANE_W +: `LPIF_LANE_W] = {stb, sup[i*`LPIF_SLICE_W +: `LPIF_SLICE_W]};
    end
    return lanes;
  endfunction

  // Credits the user still holds
  function automatic int user_credits();
    return `LPIF_BUF_DEPTH - (pushed_cnt - credit_cnt);
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [79:0] expected,
                       input logic [79:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("Error %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_wr);
  endtask

  // Drives one word this cycle; deliver says if it must reach upstream
  task automatic drive_word(input logic deliver);
    logic [31:0] r;
    r            = rand32();
    dstrm_valid  = 1'b1;
    dstrm_state  = r[3:0];
    dstrm_protid = r[5:4];
    dstrm_data   = {rand32(), rand32()};
    lane_q.push_back({dstrm_state, dstrm_protid, dstrm_data});
    if (deliver) begin
      exp_q.push_back({dstrm_state, dstrm_protid, dstrm_data});
    end
    pushed_cnt++;
  endtask

  // Fresh link per test, both ends offline
  task automatic apply_reset(input lpif_pkg::credit_t credit);
    arst_n                 = 1'b0;
    tx_online              = 1'b0;
    rx_online              = 1'b0;
    dstrm_valid            = 1'b0;
    ustrm_ready            = 1'b0;
    init_downstream_credit = credit;
    exp_q.delete();
    lane_q.delete();
    pushed_cnt = 0;
    credit_cnt = 0;
    wait_cycles(3);
    arst_n = 1'b1;
    @(negedge clk_wr);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor

  always @(posedge clk_wr) begin
    if (!arst_n) begin
      pop_hist = '0;
    end else begin
      // Word on the lanes, credit bit from the pop three samples ago
      if (tx_phy3[VLD_BIT]) begin
        if (lane_q.size() == 0) begin
          fail_run("Valid word on the tx lanes although no word is waiting");
        end
        mon_flit = lane_q.pop_front();
        check("lane_packing",
              lane_pack(mon_flit, 1'b1, pop_hist[2], tx_phy0[`LPIF_LANE_W-1], tx_mrk_userbit),
              {tx_phy3, tx_phy2, tx_phy1, tx_phy0});
      end
      pop_hist = {pop_hist[1:0], ustrm_valid && ustrm_ready};
      // Upstream pop against the oldest expected word
      if (ustrm_valid && ustrm_ready) begin
        if (exp_q.size() == 0) begin
          fail_run("Upstream delivered a word that was never expected");
        end
        mon_flit = exp_q.pop_front();
        check("ordered_delivery", 80'(mon_flit),
              80'({ustrm_state, ustrm_protid, ustrm_data}));
      end
      if (dstrm_credit) begin
        credit_cnt++;
      end
    end
  end

  // Hang guard
  always @(posedge clk_wr) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timed out after %0d cycles before the tests finished",
                         TIMEOUT_CYCLES));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    int          sent;
    logic [31:0] r;
    clk_wr         = 1'b0;
    cycle_cnt      = 0;
    rng            = 32'd93904;
    tx_mrk_userbit = 4'ha;
    delay_x_value  = 16'd3;
    delay_y_value  = 16'd5;
    dstrm_state    = '0;
    dstrm_protid   = '0;
    dstrm_data     = '0;
    apply_reset(8'd8);

    // Quiet outputs until tx online delay runs out
    tx_online = 1'b1;
    rx_online = 1'b1;
    repeat (6) begin
      @(negedge clk_wr);
      check("reset_phy", 80'(0), {tx_phy3, tx_phy2, tx_phy1, tx_phy0});
      check("reset_handshake", 80'(0), 80'({dstrm_credit, ustrm_valid}));
    end

    // Random traffic with random back-pressure
    sent = 0;
    while (sent < NUM_RANDOM) begin
      r           = rand32();
      ustrm_ready = r[0];
      if (r[1] && user_credits() > 0) begin
        drive_word(1'b1);
        sent++;
      end else begin
        dstrm_valid = 1'b0;
      end
      @(negedge clk_wr);
    end
    dstrm_valid = 1'b0;
    ustrm_ready = 1'b1;
    while (exp_q.size() != 0) @(negedge clk_wr);
    wait_cycles(16);
    check("user_credits_random", 80'(pushed_cnt), 80'(credit_cnt));

    // Link credits cap the words in flight
    apply_reset(8'd3);
    tx_online = 1'b1;
    rx_online = 1'b1;
    repeat (6) begin
      drive_word(1'b1);
      @(negedge clk_wr);
    end
    dstrm_valid = 1'b0;
    while (credit_cnt < 3) @(negedge clk_wr);
    wait_cycles(10);
    check("credit_limit_sent", 80'(3), 80'(tx_debug_status[31:16]));
    check("credit_limit_credit", 80'(0), 80'(tx_debug_status[7:0]));
    check("credit_limit_rx_fill", 80'(3), 80'(rx_debug_status[7:0]));
    ustrm_ready = 1'b1;
    while (exp_q.size() != 0) @(negedge clk_wr);
    wait_cycles(16);
    check("credit_limit_refill", 80'(3), 80'(tx_debug_status[7:0]));
    check("credit_limit_total", 80'(6), 80'(tx_debug_status[31:16]));
    check("user_credits_limit", 80'(pushed_cnt), 80'(credit_cnt));

    // Receiver offline drops words, later words arrive once it is up
    apply_reset(8'd8);
    tx_online   = 1'b1;
    ustrm_ready = 1'b1;
    repeat (4) begin
      drive_word(1'b0);
      @(negedge clk_wr);
      check("rx_gating", 80'(0), 80'(ustrm_valid));
    end
    dstrm_valid = 1'b0;
    while (credit_cnt < 4) begin
      @(negedge clk_wr);
      check("rx_gating", 80'(0), 80'(ustrm_valid));
    end
    repeat (10) begin
      @(negedge clk_wr);
      check("rx_gating", 80'(0), 80'(ustrm_valid));
    end
    rx_online = 1'b1;
    wait_cycles(int'(delay_x_value) + 3);
    repeat (4) begin
      drive_word(1'b1);
      @(negedge clk_wr);
    end
    dstrm_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_wr);
    wait_cycles(16);
    // Four credits went with the dropped words
    check("rx_gating_credit", 80'(4), 80'(tx_debug_status[7:0]));
    check("rx_gating_count", 80'(4), 80'(rx_debug_status[31:16]));
    check("user_credits_gating", 80'(pushed_cnt), 80'(credit_cnt));

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* lpif_consts.svh */
////////////////////////////////////////////////////////////////////////////
// Shared sizes of the logic link: lanes, widths, buffer depth and strobe
// period. Include this where a module or the package needs a size.
////////////////////////////////////////////////////////////////////////////

`ifndef LPIF_CONSTS_SVH
`define LPIF_CONSTS_SVH

// Number of PHY lanes the link is striped over
`define LPIF_LANES      4

// User data width
`define LPIF_DATA_W     64

// Packed flit: state 4, protocol id 2, data 64
`define LPIF_FLIT_W     70

// Payload bits carried by one lane
`define LPIF_SLICE_W    19

// Lane word on the PHY, strobe bit on top of the slice
`define LPIF_LANE_W     20

// Entries in the tx and rx buffers
`define LPIF_BUF_DEPTH  8

// Cycles between persistent strobes
`define LPIF_STB_PERIOD 16

`endif

/* run.sh */
#!/bin/sh
# Builds the loopback testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module lpif_link_tb -o lpif_sim

output=$(./obj_dir/lpif_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "^Simulation finished: PASS$"; then
  exit 0
else
  exit 1
fi

/* source/lpif_auto_sync.sv */
////////////////////////////////////////////////////////////////////////////
// Delays tx and rx online, and drives the persistent strobe and marker bits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "lpif_consts.svh"

module lpif_auto_sync (
  input  logic             clk_wr,
  input  logic             arst_n,
  input  logic             tx_online,
  input  logic             rx_online,
  input  logic [3:0]       tx_mrk_userbit,
  input  lpif_pkg::delay_t delay_x_value,
  input  lpif_pkg::delay_t delay_y_value,
  output logic             tx_online_delay,
  output logic             rx_online_delay,
  output logic             tx_auto_stb,
  output logic [3:0]       tx_auto_mrk
);

  localparam int STB_CNT_W = $clog2(`LPIF_STB_PERIOD);

  // Index 0 is the tx side, index 1 the rx side
  logic                  online_in [2];
  lpif_pkg::delay_t      delay_in  [2];
  lpif_pkg::sync_state_t state     [2];
  lpif_pkg::delay_t      wait_cnt  [2];
  logic [STB_CNT_W-1:0]  stb_cnt;

  assign online_in[0] = tx_online;
  assign online_in[1] = rx_online;
  assign delay_in[0]  = delay_y_value;
  assign delay_in[1]  = delay_x_value;

  //////////////////////////////////////////////////////////////////////////
  // Delay machines

  // Online to delayed online in delay+1 cycles, back to idle when it drops
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2; i++) begin
        state[i]    <= lpif_pkg::SYNC_IDLE;
        wait_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!online_in[i]) begin
          state[i]    <= lpif_pkg::SYNC_IDLE;
          wait_cnt[i] <= '0;
        end else begin
          case (state[i])
            lpif_pkg::SYNC_IDLE: begin
              // Zero delay skips the wait state
              wait_cnt[i] <= 16'd1;
              state[i]    <= (delay_in[i] == '0) ? lpif_pkg::SYNC_ONLINE
                                                 : lpif_pkg::SYNC_WAIT;
            end
            lpif_pkg::SYNC_WAIT: begin
              if (wait_cnt[i] == delay_in[i]) begin
                state[i] <= lpif_pkg::SYNC_ONLINE;
              end else begin
                wait_cnt[i] <= wait_cnt[i] + 16'd1;
              end
            end
            default: begin
              // Online holds until the input falls
              state[i] <= state[i];
            end
          endcase
        end
      end
    end
  end

  assign tx_online_delay = (state[0] == lpif_pkg::SYNC_ONLINE);
  assign rx_online_delay = (state[1] == lpif_pkg::SYNC_ONLINE);

  //////////////////////////////////////////////////////////////////////////
  // Strobe and marker

  // Period counter starts at zero on the first online cycle
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      stb_cnt <= '0;
    end else if (!tx_online_delay) begin
      stb_cnt <= '0;
    end else if (stb_cnt == STB_CNT_W'(`LPIF_STB_PERIOD - 1)) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt + 1'b1;
    end
  end

  assign tx_auto_stb = tx_online_delay && (stb_cnt == '0);
  // Marker only while online
  assign tx_auto_mrk = tx_online_delay ? tx_mrk_userbit : 4'h0;

endmodule

`default_nettype wire

/* source/lpif_lane.sv */
////////////////////////////////////////////////////////////////////////////
// One PHY lane: tx retiming register, rx strobe lock and rx slice register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "lpif_consts.svh"

module lpif_lane (
  input  logic                 clk_wr,
  input  logic                 arst_n,
  input  lpif_pkg::slice_t     tx_slice,
  input  logic                 tx_stb,
  input  lpif_pkg::lane_word_t rx_phy,
  output lpif_pkg::lane_word_t tx_phy,
  output lpif_pkg::slice_t     rx_slice,
  output logic                 lane_locked
);

  // Tx word and lock flag
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy      <= '0;
      lane_locked <= 1'b0;
    end else begin
      // Strobe rides on top of the slice
      tx_phy <= {tx_stb, tx_slice};
      // First strobe seen locks the lane for good
      if (rx_phy[`LPIF_LANE_W-1]) begin
        lane_locked <= 1'b1;
      end
    end
  end

  // Rx payload, strobe dropped
  always_ff @(posedge clk_wr) begin
    rx_slice <= rx_phy[`LPIF_SLICE_W-1:0];
  end

endmodule

`default_nettype wire

/* source/lpif_lane_merge.sv */
////////////////////////////////////////////////////////////////////////////
// Joins locked lane slices, unpacks the flit and the credit-return bit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "lpif_consts.svh"

module lpif_lane_merge (
  input  logic             clk_wr,
  input  logic             arst_n,
  input  lpif_pkg::slice_t rx_slice0,
  input  lpif_pkg::slice_t rx_slice1,
  input  lpif_pkg::slice_t rx_slice2,
  input  lpif_pkg::slice_t rx_slice3,
  input  logic             lane_locked0,
  input  logic             lane_locked1,
  input  logic             lane_locked2,
  input  logic             lane_locked3,
  input  logic             rx_online_delay,
  output lpif_pkg::flit_t  rx_flit,
  output logic             rx_flit_valid,
  output logic             credit_rcvd
);

  // Bits of lane 3 below the marker
  localparam int TOP_W = `LPIF_FLIT_W + 2 - 3 * `LPIF_SLICE_W;

  // Credit bit, valid bit, flit
  logic [`LPIF_FLIT_W+1:0] joined;
  logic                    rx_enable;

  assign joined    = {rx_slice3[TOP_W-1:0], rx_slice2, rx_slice1, rx_slice0};
  // All lanes aligned and receiver up
  assign rx_enable = lane_locked0 && lane_locked1 && lane_locked2 &&
                     lane_locked3 && rx_online_delay;

  always_ff @(posedge clk_wr) begin
    rx_flit <= joined[`LPIF_FLIT_W-1:0];
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_flit_valid <= 1'b0;
      credit_rcvd   <= 1'b0;
    end else begin
      rx_flit_valid <= rx_enable && joined[`LPIF_FLIT_W];
      credit_rcvd   <= rx_enable && joined[`LPIF_FLIT_W+1];
    end
  end

endmodule

`default_nettype wire

/* source/lpif_lane_stripe.sv */
////////////////////////////////////////////////////////////////////////////
// Packs marker, credit return, valid and flit, then slices them per lane
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "lpif_consts.svh"

module lpif_lane_stripe (
  input  logic             clk_wr,
  input  logic             arst_n,
  input  lpif_pkg::flit_t  tx_flit,
  input  logic             tx_flit_valid,
  input  logic             credit_return,
  input  logic             tx_auto_stb,
  input  logic [3:0]       tx_auto_mrk,
  input  logic             tx_online_delay,
  output lpif_pkg::slice_t lane_slice0,
  output lpif_pkg::slice_t lane_slice1,
  output lpif_pkg::slice_t lane_slice2,
  output lpif_pkg::slice_t lane_slice3,
  output logic             lane_stb
);

  localparam int SLICE_W = `LPIF_SLICE_W;
  localparam int SUPER_W = `LPIF_LANES * `LPIF_SLICE_W;

  // Marker, credit bit, valid bit, flit from the top down
  logic [SUPER_W-1:0] super_q;

  // Line stays quiet while offline
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      super_q  <= '0;
      lane_stb <= 1'b0;
    end else if (!tx_online_delay) begin
      super_q  <= '0;
      lane_stb <= 1'b0;
    end else begin
      super_q  <= {tx_auto_mrk, credit_return, tx_flit_valid, tx_flit};
      lane_stb <= tx_auto_stb;
    end
  end

  // Lane 0 takes the lowest slice
  assign lane_slice0 = super_q[0*SLICE_W +: SLICE_W];
  assign lane_slice1 = super_q[1*SLICE_W +: SLICE_W];
  assign lane_slice2 = super_q[2*SLICE_W +: SLICE_W];
  assign lane_slice3 = super_q[3*SLICE_W +: SLICE_W];

endmodule

`default_nettype wire

/* source/lpif_link_top.sv */
////////////////////////////////////////////////////////////////////////////
// Logic link top: auto-sync, tx and rx link, stripe, four lanes and merge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "lpif_consts.svh"

module lpif_link_top (
  input  logic                    clk_wr,
  input  logic                    arst_n,
  // Control
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  logic [3:0]              tx_mrk_userbit,
  input  lpif_pkg::delay_t        delay_x_value,
  input  lpif_pkg::delay_t        delay_y_value,
  input  lpif_pkg::credit_t       init_downstream_credit,
  // Downstream channel
  input  logic                    dstrm_valid,
  input  logic [3:0]              dstrm_state,
  input  logic [1:0]              dstrm_protid,
  input  logic [`LPIF_DATA_W-1:0] dstrm_data,
  output logic                    dstrm_credit,
  // Upstream channel
  output logic                    ustrm_valid,
  output logic [3:0]              ustrm_state,
  output logic [1:0]              ustrm_protid,
  output logic [`LPIF_DATA_W-1:0] ustrm_data,
  input  logic                    ustrm_ready,
  // Debug
  output logic [31:0]             tx_debug_status,
  output logic [31:0]             rx_debug_status,
  // PHY
  output lpif_pkg::lane_word_t    tx_phy0,
  output lpif_pkg::lane_word_t    tx_phy1,
  output lpif_pkg::lane_word_t    tx_phy2,
  output lpif_pkg::lane_word_t    tx_phy3,
  input  lpif_pkg::lane_word_t    rx_phy0,
  input  lpif_pkg::lane_word_t    rx_phy1,
  input  lpif_pkg::lane_word_t    rx_phy2,
  input  lpif_pkg::lane_word_t    rx_phy3
);

  //////////////////////////////////////////////////////////////////////////
  // Interconnect

  logic                 tx_online_delay;
  logic                 rx_online_delay;
  logic                 tx_auto_stb;
  logic [3:0]           tx_auto_mrk;
  lpif_pkg::flit_t      tx_flit;
  logic                 tx_flit_valid;
  lpif_pkg::flit_t      rx_flit;
  logic                 rx_flit_valid;
  logic                 credit_return;
  logic                 credit_rcvd;
  logic                 lane_stb;
  lpif_pkg::slice_t     tx_slice    [`LPIF_LANES];
  lpif_pkg::slice_t     rx_slice    [`LPIF_LANES];
  lpif_pkg::lane_word_t tx_phy_w    [`LPIF_LANES];
  lpif_pkg::lane_word_t rx_phy_w    [`LPIF_LANES];
  logic                 lane_locked [`LPIF_LANES];

  assign tx_phy0     = tx_phy_w[0];
  assign tx_phy1     = tx_phy_w[1];
  assign tx_phy2     = tx_phy_w[2];
  assign tx_phy3     = tx_phy_w[3];
  assign rx_phy_w[0] = rx_phy0;
  assign rx_phy_w[1] = rx_phy1;
  assign rx_phy_w[2] = rx_phy2;
  assign rx_phy_w[3] = rx_phy3;

  //////////////////////////////////////////////////////////////////////////
  // Sync and link layers

  lpif_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_auto_stb     (tx_auto_stb),
    .tx_auto_mrk     (tx_auto_mrk)
  );

  lpif_tx_link u_tx_link (
    .clk_wr                 (clk_wr),
    .arst_n                 (arst_n),
    .dstrm_valid            (dstrm_valid),
    .dstrm_state            (dstrm_state),
    .dstrm_protid           (dstrm_protid),
    .dstrm_data             (dstrm_data),
    .tx_online_delay        (tx_online_delay),
    .init_downstream_credit (init_downstream_credit),
    .credit_rcvd            (credit_rcvd),
    .dstrm_credit           (dstrm_credit),
    .tx_flit                (tx_flit),
    .tx_flit_valid          (tx_flit_valid),
    .tx_debug_status        (tx_debug_status)
  );

  lpif_rx_link u_rx_link (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .rx_flit         (rx_flit),
    .rx_flit_valid   (rx_flit_valid),
    .ustrm_ready     (ustrm_ready),
    .ustrm_valid     (ustrm_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .credit_return   (credit_return),
    .rx_debug_status (rx_debug_status)
  );

  //////////////////////////////////////////////////////////////////////////
  // Stripe, lanes and merge

  lpif_lane_stripe u_stripe (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_flit         (tx_flit),
    .tx_flit_valid   (tx_flit_valid),
    .credit_return   (credit_return),
    .tx_auto_stb     (tx_auto_stb),
    .tx_auto_mrk     (tx_auto_mrk),
    .tx_online_delay (tx_online_delay),
    .lane_slice0     (tx_slice[0]),
    .lane_slice1     (tx_slice[1]),
    .lane_slice2     (tx_slice[2]),
    .lane_slice3     (tx_slice[3]),
    .lane_stb        (lane_stb)
  );

  // Every lane carries the same strobe
  for (genvar i = 0; i < `LPIF_LANES; i++) begin : g_lane
    lpif_lane u_lane (
      .clk_wr      (clk_wr),
      .arst_n      (arst_n),
      .tx_slice    (tx_slice[i]),
      .tx_stb      (lane_stb),
      .rx_phy      (rx_phy_w[i]),
      .tx_phy      (tx_phy_w[i]),
      .rx_slice    (rx_slice[i]),
      .lane_locked (lane_locked[i])
    );
  end

  lpif_lane_merge u_merge (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .rx_slice0       (rx_slice[0]),
    .rx_slice1       (rx_slice[1]),
    .rx_slice2       (rx_slice[2]),
    .rx_slice3       (rx_slice[3]),
    .lane_locked0    (lane_locked[0]),
    .lane_locked1    (lane_locked[1]),
    .lane_locked2    (lane_locked[2]),
    .lane_locked3    (lane_locked[3]),
    .rx_online_delay (rx_online_delay),
    .rx_flit         (rx_flit),
    .rx_flit_valid   (rx_flit_valid),
    .credit_rcvd     (credit_rcvd)
  );

endmodule

`default_nettype wire

/* source/lpif_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Types shared by the logic link blocks, referenced as lpif_pkg::name
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "lpif_consts.svh"

package lpif_pkg;

  // One packed user word
  typedef logic [`LPIF_FLIT_W-1:0]  flit_t;

  // Word on one PHY lane, strobe bit on top
  typedef logic [`LPIF_LANE_W-1:0]  lane_word_t;

  // Payload part of a lane word
  typedef logic [`LPIF_SLICE_W-1:0] slice_t;

  // Credit counts
  typedef logic [7:0]               credit_t;

  // Delay settings in cycles
  typedef logic [15:0]              delay_t;

  // Debug word counters
  typedef logic [15:0]              count_t;

  // Online delay machine
  typedef enum logic [1:0] {
    SYNC_IDLE,
    SYNC_WAIT,
    SYNC_ONLINE
  } sync_state_t;

endpackage

`default_nettype wire

/* source/lpif_rx_link.sv */
////////////////////////////////////////////////////////////////////////////
// Receive side: buffers flits, drives upstream, returns a credit per pop
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "lpif_consts.svh"

module lpif_rx_link (
  input  logic                    clk_wr,
  input  logic                    arst_n,
  input  lpif_pkg::flit_t         rx_flit,
  input  logic                    rx_flit_valid,
  input  logic                    ustrm_ready,
  output logic                    ustrm_valid,
  output logic [3:0]              ustrm_state,
  output logic [1:0]              ustrm_protid,
  output logic [`LPIF_DATA_W-1:0] ustrm_data,
  output logic                    credit_return,
  output logic [31:0]             rx_debug_status
);

  localparam int PTR_W = $clog2(`LPIF_BUF_DEPTH);

  lpif_pkg::flit_t  buf_mem [`LPIF_BUF_DEPTH];
  lpif_pkg::flit_t  head;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   fill;
  lpif_pkg::count_t rcvd_cnt;
  logic             pop;

  // Head of buffer shown upstream
  assign head        = buf_mem[rd_ptr];
  assign ustrm_valid = (fill != '0);
  assign {ustrm_state, ustrm_protid, ustrm_data} = head;
  assign pop         = ustrm_valid && ustrm_ready;

  // Flit storage
  always_ff @(posedge clk_wr) begin
    if (rx_flit_valid) begin
      buf_mem[wr_ptr] <= rx_flit;
    end
  end

  // Link credits keep the buffer from overflowing
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill          <= '0;
      rcvd_cnt      <= '0;
      credit_return <= 1'b0;
    end else begin
      if (rx_flit_valid) begin
        wr_ptr   <= wr_ptr + 1'b1;
        rcvd_cnt <= rcvd_cnt + 16'd1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({rx_flit_valid, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // Freed entry goes back to the far transmitter
      credit_return <= pop;
    end
  end

  // Received words on top, buffer fill in the low byte
  assign rx_debug_status = {rcvd_cnt, 8'h00, 8'(fill)};

endmodule

`default_nettype wire

/* source/lpif_tx_link.sv */
////////////////////////////////////////////////////////////////////////////
// Transmit side: buffers user words and sends them against link credits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "lpif_consts.svh"

module lpif_tx_link (
  input  logic                    clk_wr,
  input  logic                    arst_n,
  input  logic                    dstrm_valid,
  input  logic [3:0]              dstrm_state,
  input  logic [1:0]              dstrm_protid,
  input  logic [`LPIF_DATA_W-1:0] dstrm_data,
  input  logic                    tx_online_delay,
  input  lpif_pkg::credit_t       init_downstream_credit,
  input  logic                    credit_rcvd,
  output logic                    dstrm_credit,
  output lpif_pkg::flit_t         tx_flit,
  output logic                    tx_flit_valid,
  output logic [31:0]             tx_debug_status
);

  localparam int PTR_W = $clog2(`LPIF_BUF_DEPTH);

  lpif_pkg::flit_t   buf_mem [`LPIF_BUF_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    fill;
  lpif_pkg::credit_t link_credit;
  lpif_pkg::count_t  sent_cnt;
  logic              online_q;
  logic              pop;

  // Send when a word waits, the far end has room and the link is up
  assign pop           = (fill != '0) && (link_credit != '0) && tx_online_delay;
  assign tx_flit       = buf_mem[rd_ptr];
  assign tx_flit_valid = pop;

  // Word storage
  always_ff @(posedge clk_wr) begin
    if (dstrm_valid) begin
      buf_mem[wr_ptr] <= {dstrm_state, dstrm_protid, dstrm_data};
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Buffer control and user credits

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      fill         <= '0;
      dstrm_credit <= 1'b0;
      sent_cnt     <= '0;
    end else begin
      if (dstrm_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr   <= rd_ptr + 1'b1;
        sent_cnt <= sent_cnt + 16'd1;
      end
      case ({dstrm_valid, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // One user credit per word leaving the buffer
      dstrm_credit <= pop;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Link credit counter

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      online_q    <= 1'b0;
      link_credit <= '0;
    end else begin
      online_q <= tx_online_delay;
      if (!tx_online_delay) begin
        link_credit <= '0;
      end else if (!online_q) begin
        // Load on the rising edge of online
        link_credit <= init_downstream_credit;
      end else begin
        // Send and return together cancel out
        case ({pop, credit_rcvd})
          2'b10:   link_credit <= link_credit - 8'd1;
          2'b01:   link_credit <= link_credit + 8'd1;
          default: link_credit <= link_credit;
        endcase
      end
    end
  end

  // Sent words on top, live credits in the low byte
  assign tx_debug_status = {sent_cnt, 8'h00, link_credit};

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
source/lpif_pkg.sv
source/lpif_auto_sync.sv
source/lpif_tx_link.sv
source/lpif_lane_stripe.sv
source/lpif_lane.sv
source/lpif_lane_merge.sv
source/lpif_rx_link.sv
source/lpif_link_top.sv
bench/lpif_link_tb.sv
